/* alu.sv */
// ALU operations, flag generation and the flag register
`timescale 1ns/1ps

module alu (
    input  logic              clk,
    input  logic              arst_n,
    input  cpu_pkg::data_t    a,
    input  cpu_pkg::data_t    b,
    input  cpu_pkg::alu_op_e  alu_op,
    input  logic              flags_we,
    output cpu_pkg::data_t    result,
    output cpu_pkg::flags_t   flags
);

    logic [8:0]      sum;                   // Result with carry or borrow on top
    logic [15:0]     prod;
    logic            c_in;                  // Registered carry for adc and sbc
    logic            c_next;
    logic            o_next;
    cpu_pkg::flags_t flags_next;

    assign prod = a * b;
    assign c_in = flags[cpu_pkg::FLAG_C];

    always_comb begin
        sum    = '0;
        o_next = 1'b0;
        case (alu_op)
            cpu_pkg::op_pass_a: sum[7:0] = a;
            cpu_pkg::op_pass_b: sum[7:0] = b;
            cpu_pkg::op_add:    sum = {1'b0, a} + {1'b0, b};
            cpu_pkg::op_adc:    sum = {1'b0, a} + {1'b0, b} + c_in;
            cpu_pkg::op_sub:    sum = {1'b0, a} - {1'b0, b};        // Bit 8 is borrow
            cpu_pkg::op_sbc:    sum = {1'b0, a} - {1'b0, b} - c_in;
            cpu_pkg::op_rsub:   sum = {1'b0, b} - {1'b0, a};
            cpu_pkg::op_and:    sum[7:0] = a & b;
            cpu_pkg::op_or:     sum[7:0] = a | b;
            cpu_pkg::op_xor:    sum[7:0] = a ^ b;
            cpu_pkg::op_not_b:  sum[7:0] = ~b;
            cpu_pkg::op_shl_a:  sum = {a, 1'b0};                    // Top bit out to carry
            cpu_pkg::op_shr_a:  sum = {a[0], 1'b0, a[7:1]};         // Bottom bit out to carry
            cpu_pkg::op_mul_lo: sum[7:0] = prod[7:0];
            cpu_pkg::op_mul_hi: sum[7:0] = prod[15:8];
            default:            sum = '0;                           // op_zero
        endcase

        // Signed overflow, add and subtract families only
        case (alu_op)
            cpu_pkg::op_add, cpu_pkg::op_adc:
                o_next = (a[7] == b[7]) && (sum[7] != a[7]);
            cpu_pkg::op_sub, cpu_pkg::op_sbc:
                o_next = (a[7] != b[7]) && (sum[7] != a[7]);
            cpu_pkg::op_rsub:
                o_next = (a[7] != b[7]) && (sum[7] != b[7]);
            default:
                o_next = 1'b0;
        endcase
    end

    assign result = sum[7:0];
    assign c_next = sum[8];                 // Zero for ops that leave bit 8 clear

    // c z o n gt lt eq ne
    assign flags_next = {c_next, (result == '0), o_next, result[7],
                         (a > b), (a < b), (a == b), (a != b)};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (flags_we) begin
            flags <= flags_next;
        end
    end

endmodule

/* compile.f */
cpu_pkg.sv
controller.sv
pc.sv
register_file.sv
alu.sv
operand_select.sv
memory_io.sv
cpu.sv
cpu_checker.sv
tb_cpu.sv

/* controller.sv */
// Program memory, instruction decode, execute condition and qualified write strobes
`timescale 1ns/1ps

module controller (
    input  logic                  clk,
    input  logic                  prog_we,
    input  cpu_pkg::addr_t        prog_addr,
    input  cpu_pkg::instr_t       prog_data,
    input  cpu_pkg::addr_t        pc_addr,
    input  logic                  run,
    input  cpu_pkg::flags_t       flags,
    input  logic                  in_valid,
    input  logic                  out_ready,
    output cpu_pkg::alu_op_e      alu_op,
    output cpu_pkg::adev_e        adev,
    output cpu_pkg::bdev_e        bdev,
    output cpu_pkg::addr_mode_e   addr_mode,
    output cpu_pkg::data_t        immed8,
    output logic                  reg_we,
    output logic [1:0]            reg_waddr,
    output logic                  mar_we,
    output logic                  ram_we,
    output logic                  pc_load,
    output logic                  out_we,
    output logic                  in_read,
    output logic                  flags_we
);

    cpu_pkg::instr_t prog_mem [cpu_pkg::PROG_DEPTH];   // Program store

    cpu_pkg::instr_t instr;             // Word at the current PC
    cpu_pkg::targ_e  targ;
    cpu_pkg::cond_e  cond;
    logic            set_flags;
    logic            cond_true;         // Selected condition holds
    logic            exec;              // Instruction takes effect this cycle

    // Loaded only while the CPU is stopped
    always_ff @(posedge clk) begin
        if (prog_we) begin
            prog_mem[prog_addr] <= prog_data;
        end
    end

    assign instr = prog_mem[pc_addr];   // Asynchronous fetch

    // Field split
    assign targ      = cpu_pkg::targ_e'(instr[cpu_pkg::TARG_LSB +: 3]);
    assign adev      = cpu_pkg::adev_e'(instr[cpu_pkg::ADEV_LSB +: 3]);
    assign bdev      = cpu_pkg::bdev_e'(instr[cpu_pkg::BDEV_LSB +: 3]);
    assign alu_op    = cpu_pkg::alu_op_e'(instr[cpu_pkg::ALU_OP_LSB +: 4]);
    assign cond      = cpu_pkg::cond_e'(instr[cpu_pkg::COND_LSB +: 4]);
    assign set_flags = instr[cpu_pkg::SET_FLAGS_BIT];
    assign addr_mode = cpu_pkg::addr_mode_e'(instr[cpu_pkg::ADDR_MODE_BIT]);
    assign immed8    = instr[cpu_pkg::IMMED_LSB +: 8];

    // Condition against registered flags and the two port levels
    always_comb begin
        case (cond)
            cpu_pkg::cond_always: cond_true = 1'b1;
            cpu_pkg::cond_c:      cond_true = flags[cpu_pkg::FLAG_C];
            cpu_pkg::cond_z:      cond_true = flags[cpu_pkg::FLAG_Z];
            cpu_pkg::cond_o:      cond_true = flags[cpu_pkg::FLAG_O];
            cpu_pkg::cond_n:      cond_true = flags[cpu_pkg::FLAG_N];
            cpu_pkg::cond_gt:     cond_true = flags[cpu_pkg::FLAG_GT];
            cpu_pkg::cond_lt:     cond_true = flags[cpu_pkg::FLAG_LT];
            cpu_pkg::cond_eq:     cond_true = flags[cpu_pkg::FLAG_EQ];
            cpu_pkg::cond_ne:     cond_true = flags[cpu_pkg::FLAG_NE];
            cpu_pkg::cond_di:     cond_true = in_valid;     // Input byte waiting
            cpu_pkg::cond_do:     cond_true = out_ready;    // Output side can take a byte
            default:              cond_true = 1'b0;         // Spare codes never run
        endcase
    end

    assign exec = run & cond_true;

    // One strobe per target, all gated by exec
    assign reg_we    = exec & ~targ[2];                     // rega..regd
    assign reg_waddr = targ[1:0];
    assign mar_we    = exec & (targ == cpu_pkg::targ_mar);
    assign ram_we    = exec & (targ == cpu_pkg::targ_ram);
    assign pc_load   = exec & (targ == cpu_pkg::targ_pc);   // Jump
    assign out_we    = exec & (targ == cpu_pkg::targ_uart);
    assign in_read   = exec & (adev == cpu_pkg::adev_uart); // Consumes in_data
    assign flags_we  = exec & set_flags;

endmodule

/* cpu.sv */
// Top level wiring controller, PC, register file, ALU, operand select and memory/IO
`timescale 1ns/1ps

module cpu (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             run,
    input  logic             prog_we,
    input  cpu_pkg::addr_t   prog_addr,
    input  cpu_pkg::instr_t  prog_data,
    input  cpu_pkg::data_t   in_data,
    input  logic             in_valid,
    input  logic             out_ready,
    output cpu_pkg::data_t   out_data,
    output logic             out_strobe,
    output logic             in_read
);

    cpu_pkg::alu_op_e     alu_op;
    cpu_pkg::adev_e       adev;
    cpu_pkg::bdev_e       bdev;
    cpu_pkg::addr_mode_e  addr_mode;
    cpu_pkg::data_t       immed8;
    logic                 reg_we;
    logic [1:0]           reg_waddr;
    logic                 mar_we, ram_we, pc_load, out_we, flags_we;
    cpu_pkg::addr_t       pc_addr;
    cpu_pkg::flags_t      flags;
    cpu_pkg::data_t       rdata_a, rdata_b;
    cpu_pkg::data_t       mar, ram_rdata;
    cpu_pkg::data_t       abus, bbus;
    cpu_pkg::data_t       result;           // Write data for every target

    controller ctrl_i (
        .clk, .prog_we, .prog_addr, .prog_data, .pc_addr, .run, .flags,
        .in_valid, .out_ready,
        .alu_op, .adev, .bdev, .addr_mode, .immed8,
        .reg_we, .reg_waddr, .mar_we, .ram_we, .pc_load, .out_we, .in_read, .flags_we
    );

    pc pc_i (
        .clk, .arst_n, .run, .pc_load, .result, .pc_addr
    );

    register_file regs_i (
        .clk, .arst_n,
        .we      (reg_we),
        .waddr   (reg_waddr),
        .wdata   (result),
        .raddr_a (adev[1:0]),               // Low bits pick the register
        .raddr_b (bdev[1:0]),
        .rdata_a, .rdata_b
    );

    operand_select opsel_i (
        .adev, .bdev, .rdata_a, .rdata_b, .mar, .ram_rdata, .in_data, .immed8,
        .abus, .bbus
    );

    alu alu_i (
        .clk, .arst_n,
        .a (abus),
        .b (bbus),
        .alu_op, .flags_we, .result, .flags
    );

    memory_io memio_i (
        .clk, .arst_n, .mar_we, .ram_we, .out_we, .addr_mode, .immed8, .result,
        .mar, .ram_rdata, .out_data, .out_strobe
    );

endmodule

/* cpu_checker.sv */
// Bound assertions on run, program load, input read and output strobe rules of the cpu top level
`timescale 1ns/1ps

module cpu_checker (
    input logic clk,
    input logic arst_n,
    input logic run,
    input logic prog_we,
    input logic in_read,
    input logic out_strobe
);

    // No input consumed while stopped
    a_no_read_stopped: assert property (@(posedge clk) disable iff (!arst_n)
        !run |-> !in_read) else $error("in_read high while run is low");

    // A strobe follows an executed write, so run was high one cycle earlier
    a_strobe_after_run: assert property (@(posedge clk) disable iff (!arst_n)
        out_strobe |-> $past(run)) else $error("out_strobe without run in the cycle before");

    a_no_load_running: assert property (@(posedge clk) disable iff (!arst_n)
        run |-> !prog_we) else $error("prog_we high while run is high");

    // Port pulses stay quiet in reset
    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!out_strobe && !in_read)) else $error("port pulse during reset");

endmodule

bind cpu cpu_checker cpu_checker_i (.*);

/* cpu_pkg.sv */
// Shared widths, instruction field layout, flag positions, device, ALU-op and condition encodings
package cpu_pkg;

    localparam int DATA_W     = 8;          // Byte datapath
    localparam int ADDR_W     = 8;          // Program and RAM address
    localparam int INSTR_W    = 27;         // One instruction word
    localparam int PROG_DEPTH = 256;        // Program words
    localparam int RAM_DEPTH  = 256;        // RAM bytes

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [7:0]         flags_t;    // c z o n gt lt eq ne, c at the top

    // Instruction field positions, top field first
    localparam int TARG_LSB      = 24;      // [26:24]
    localparam int ADEV_LSB      = 21;      // [23:21]
    localparam int BDEV_LSB      = 18;      // [20:18]
    localparam int ALU_OP_LSB    = 14;      // [17:14]
    localparam int COND_LSB      = 10;      // [13:10]
    localparam int SET_FLAGS_BIT = 9;
    localparam int ADDR_MODE_BIT = 8;
    localparam int IMMED_LSB     = 0;       // [7:0]

    // Bit index of each flag inside flags_t
    localparam int FLAG_C  = 7;
    localparam int FLAG_Z  = 6;
    localparam int FLAG_O  = 5;
    localparam int FLAG_N  = 4;
    localparam int FLAG_GT = 3;
    localparam int FLAG_LT = 2;
    localparam int FLAG_EQ = 1;
    localparam int FLAG_NE = 0;

    typedef enum logic [2:0] {
        targ_rega, targ_regb, targ_regc, targ_regd,
        targ_mar, targ_ram, targ_pc, targ_uart
    } targ_e;

    // Code 7 is spare and reads zero
    typedef enum logic [2:0] {
        adev_rega, adev_regb, adev_regc, adev_regd,
        adev_mar, adev_uart, adev_zero
    } adev_e;

    // Code 7 is spare and reads the immediate
    typedef enum logic [2:0] {
        bdev_rega, bdev_regb, bdev_regc, bdev_regd,
        bdev_mar, bdev_ram, bdev_immed
    } bdev_e;

    typedef enum logic [3:0] {
        op_pass_a, op_pass_b, op_add, op_sub, op_adc, op_sbc, op_rsub, op_and,
        op_or, op_xor, op_not_b, op_shl_a, op_shr_a, op_mul_lo, op_mul_hi, op_zero
    } alu_op_e;

    // Codes 11 to 15 never execute
    typedef enum logic [3:0] {
        cond_always, cond_c, cond_z, cond_o, cond_n, cond_gt,
        cond_lt, cond_eq, cond_ne, cond_di, cond_do
    } cond_e;

    typedef enum logic {
        am_direct,                          // RAM address from immed8
        am_register                         // RAM address from MAR
    } addr_mode_e;

endpackage

/* memory_io.sv */
// MAR, RAM with direct or register addressing, output byte and output strobe
`timescale 1ns/1ps

module memory_io (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 mar_we,
    input  logic                 ram_we,
    input  logic                 out_we,
    input  cpu_pkg::addr_mode_e  addr_mode,
    input  cpu_pkg::data_t       immed8,
    input  cpu_pkg::data_t       result,
    output cpu_pkg::data_t       mar,
    output cpu_pkg::data_t       ram_rdata,
    output cpu_pkg::data_t       out_data,
    output logic                 out_strobe
);

    cpu_pkg::data_t ram [cpu_pkg::RAM_DEPTH];
    cpu_pkg::addr_t ram_addr;

    assign ram_addr  = (addr_mode == cpu_pkg::am_register) ? mar : immed8;
    assign ram_rdata = ram[ram_addr];       // Read in the same cycle

    always_ff @(posedge clk) begin
        if (ram_we) begin
            ram[ram_addr] <= result;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mar        <= '0;
            out_data   <= '0;
            out_strobe <= 1'b0;
        end else begin
            if (mar_we) begin
                mar <= result;
            end
            if (out_we) begin
                out_data <= result;         // Held until the next port write
            end
            out_strobe <= out_we;           // One cycle pulse per write
        end
    end

endmodule

/* operand_select.sv */
// A-bus and B-bus source multiplexers
`timescale 1ns/1ps

module operand_select (
    input  cpu_pkg::adev_e  adev,
    input  cpu_pkg::bdev_e  bdev,
    input  cpu_pkg::data_t  rdata_a,
    input  cpu_pkg::data_t  rdata_b,
    input  cpu_pkg::data_t  mar,
    input  cpu_pkg::data_t  ram_rdata,
    input  cpu_pkg::data_t  in_data,
    input  cpu_pkg::data_t  immed8,
    output cpu_pkg::data_t  abus,
    output cpu_pkg::data_t  bbus
);

    // Register codes share one read port, addressed by adev[1:0]
    always_comb begin
        case (adev)
            cpu_pkg::adev_rega,
            cpu_pkg::adev_regb,
            cpu_pkg::adev_regc,
            cpu_pkg::adev_regd: abus = rdata_a;
            cpu_pkg::adev_mar:  abus = mar;         // MAR usable as an operand
            cpu_pkg::adev_uart: abus = in_data;     // Input port byte
            default:            abus = '0;          // adev_zero and spare code
        endcase
    end

    always_comb begin
        case (bdev)
            cpu_pkg::bdev_rega,
            cpu_pkg::bdev_regb,
            cpu_pkg::bdev_regc,
            cpu_pkg::bdev_regd: bbus = rdata_b;
            cpu_pkg::bdev_mar:  bbus = mar;
            cpu_pkg::bdev_ram:  bbus = ram_rdata;   // Direct or MAR addressed
            default:            bbus = immed8;      // bdev_immed and spare code
        endcase
    end

endmodule

/* pc.sv */
// Program counter with increment, jump load and hold while stopped
`timescale 1ns/1ps

module pc (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           run,
    input  logic           pc_load,
    input  cpu_pkg::data_t result,
    output cpu_pkg::addr_t pc_addr
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_addr <= '0;
        end else if (run) begin
            if (pc_load) begin
                pc_addr <= result;                  // Jump target from the ALU
            end else begin
                pc_addr <= pc_addr + 1'b1;          // Wraps 255 -> 0
            end
        end
        // Stopped: hold
    end

endmodule

/* register_file.sv */
// Four general registers with one write port and two asynchronous read ports
`timescale 1ns/1ps

module register_file (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           we,
    input  logic [1:0]     waddr,
    input  cpu_pkg::data_t wdata,
    input  logic [1:0]     raddr_a,
    input  logic [1:0]     raddr_b,
    output cpu_pkg::data_t rdata_a,
    output cpu_pkg::data_t rdata_b
);

    cpu_pkg::data_t regs [4];               // rega..regd

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Read ports see the old value during a write cycle
    assign rdata_a = regs[raddr_a];         // A-bus side
    assign rdata_b = regs[raddr_b];         // B-bus side

endmodule

/* run.sh */
#!/bin/sh
# Build and run the cpu testbench with Verilator

verilator --binary --timing --assert --top-module tb_cpu -f compile.f -o sim_tb_cpu > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb_cpu > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* tb_cpu.sv */
// Testbench for cpu with instruction encoder, ISA reference model, program builders and port drivers
`timescale 1ns/1ps

module tb_cpu;

    localparam int LIMIT_SUM = 200 + 600 + 200 + 1500 + 1500;  // Per-test cycle limits

    logic            clk = 1'b0;
    logic            arst_n = 1'b0;
    logic            run = 1'b0;
    logic            prog_we = 1'b0;
    cpu_pkg::addr_t  prog_addr = '0;
    cpu_pkg::instr_t prog_data = '0;
    cpu_pkg::data_t  in_data = '0;
    logic            in_valid = 1'b0;
    logic            out_ready = 1'b1;
    cpu_pkg::data_t  out_data;
    logic            out_strobe;
    logic            in_read;

    cpu_pkg::instr_t prog [256];            // Program image for the next test
    int              plen;
    cpu_pkg::data_t  in_list [$];           // Bytes offered on the input port
    cpu_pkg::data_t  exp_q [$];             // Expected output bytes
    int              got, in_idx, busy;
    logic            rd_q = 1'b0;           // in_read seen at the last edge
    logic            ready_q = 1'b1;        // out_ready seen at the last edge
    logic            gap_in = 1'b0;         // Random gaps on in_valid
    logic            drop_out = 1'b0;       // Consumer busy after each byte
    int              data_errs, count_errs, other_errs;
    string           test_name;
    int unsigned     seed_val;

    always #2 clk = ~clk;

    cpu cpu_i (.*);

    function automatic cpu_pkg::instr_t enc(cpu_pkg::targ_e t, cpu_pkg::adev_e a,
            cpu_pkg::bdev_e b, cpu_pkg::alu_op_e op, cpu_pkg::cond_e c, logic sf,
            cpu_pkg::addr_mode_e am, cpu_pkg::data_t imm);
        return {t, a, b, op, c, sf, am, imm};
    endfunction

    task automatic emit(cpu_pkg::instr_t w);
        prog[plen] = w;
        plen++;
    endtask

    task automatic mov_imm(cpu_pkg::targ_e t, cpu_pkg::data_t v);
        emit(enc(t, cpu_pkg::adev_zero, cpu_pkg::bdev_immed, cpu_pkg::op_pass_b,
                 cpu_pkg::cond_always, 1'b0, cpu_pkg::am_direct, v));
    endtask

    task automatic jump(cpu_pkg::cond_e c, cpu_pkg::data_t target);
        emit(enc(cpu_pkg::targ_pc, cpu_pkg::adev_zero, cpu_pkg::bdev_immed, cpu_pkg::op_pass_b,
                 c, 1'b0, cpu_pkg::am_direct, target));
    endtask

    // ISA model stepping one instruction at a time with di true while bytes remain and do true
    function automatic void ref_model(input int n_exp);
        cpu_pkg::data_t  r [4];
        cpu_pkg::data_t  ram_m [256];
        cpu_pkg::data_t  mar_m, a, b, res;
        cpu_pkg::flags_t f;
        cpu_pkg::addr_t  p, ma;
        cpu_pkg::instr_t w;
        int              ii, t, ad, bd, op, cd, ai, bi, ci, sa, sb, full, sfull;
        logic            c, o, ct;
        exp_q.delete();
        for (int i = 0; i < 4; i++) r[i] = '0;
        for (int i = 0; i < 256; i++) ram_m[i] = '0;
        mar_m = '0;
        f = '0;
        p = '0;
        ii = 0;
        for (int steps = 0; steps < 4000 && exp_q.size() < n_exp; steps++) begin
            w  = prog[p];
            t  = int'(w[26:24]);
            ad = int'(w[23:21]);
            bd = int'(w[20:18]);
            op = int'(w[17:14]);
            cd = int'(w[13:10]);
            ma = w[8] ? mar_m : w[7:0];                 // Register or direct RAM address
            case (ad)
                0, 1, 2, 3: a = r[ad];
                4:          a = mar_m;
                5:          a = (ii < in_list.size()) ? in_list[ii] : '0;
                default:    a = '0;
            endcase
            case (bd)
                0, 1, 2, 3: b = r[bd];
                4:          b = mar_m;
                5:          b = ram_m[ma];
                default:    b = w[7:0];
            endcase
            ai = int'(a);
            bi = int'(b);
            ci = int'(f[7]);
            sa = (ai > 127) ? ai - 256 : ai;            // Signed views
            sb = (bi > 127) ? bi - 256 : bi;
            case (op)
                0:       full = ai;
                1:       full = bi;
                2:       full = ai + bi;
                3:       full = ai - bi;
                4:       full = ai + bi + ci;
                5:       full = ai - bi - ci;
                6:       full = bi - ai;
                7:       full = ai & bi;
                8:       full = ai | bi;
                9:       full = ai ^ bi;
                10:      full = 255 - bi;
                11:      full = ai * 2;
                12:      full = ai / 2;
                13:      full = (ai * bi) % 256;
                14:      full = (ai * bi) / 256;
                default: full = 0;
            endcase
            case (op)
                2:       sfull = sa + sb;
                3:       sfull = sa - sb;
                4:       sfull = sa + sb + ci;
                5:       sfull = sa - sb - ci;
                6:       sfull = sb - sa;
                default: sfull = 0;
            endcase
            res = cpu_pkg::data_t'(full & 255);
            case (op)
                2, 4, 11: c = (full > 255);             // Carry out
                3, 5, 6:  c = (full < 0);               // Borrow
                12:       c = a[0];
                default:  c = 1'b0;
            endcase
            o = (sfull > 127) || (sfull < -128);
            case (cd)
                0:                      ct = 1'b1;
                1, 2, 3, 4, 5, 6, 7, 8: ct = f[8 - cd];
                9:                      ct = (ii < in_list.size());
                10:                     ct = 1'b1;
                default:                ct = 1'b0;
            endcase
            if (ct) begin
                case (t)
                    0, 1, 2, 3: r[t] = res;
                    4:          mar_m = res;
                    5:          ram_m[ma] = res;
                    7:          exp_q.push_back(res);
                    default:    ;
                endcase
                if (ad == 5) ii++;
                if (w[9]) f = {c, res == 8'd0, o, res[7], a > b, a < b, a == b, a != b};
            end
            p = (ct && t == 6) ? res : p + 8'd1;
        end
    endfunction

    task automatic check_data(input string name, input cpu_pkg::data_t exp,
                              input cpu_pkg::data_t act);
        if (exp !== act) begin
            data_errs++;
            $display("FAIL %s expected %02h actual %02h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            count_errs++;
            $display("FAIL %s expected %0d bytes actual %0d", name, exp, act);
        end
    endtask

    // Counted loop that branches on ne back to the output
    task automatic count_loop_prog();
        plen = 0;
        mov_imm(cpu_pkg::targ_rega, 8'd5);
        emit(enc(cpu_pkg::targ_uart, cpu_pkg::adev_rega, cpu_pkg::bdev_immed, cpu_pkg::op_pass_a,
                 cpu_pkg::cond_always, 1'b0, cpu_pkg::am_direct, 8'd0));
        emit(enc(cpu_pkg::targ_rega, cpu_pkg::adev_rega, cpu_pkg::bdev_immed, cpu_pkg::op_sub,
                 cpu_pkg::cond_always, 1'b1, cpu_pkg::am_direct, 8'd1));
        jump(cpu_pkg::cond_ne, 8'd1);
        jump(cpu_pkg::cond_always, cpu_pkg::data_t'(plen));    // Halt
    endtask

    task automatic alu_prog();
        cpu_pkg::data_t va;
        plen = 0;
        for (int k = 0; k < 3; k++) begin
            va = cpu_pkg::data_t'($urandom);
            mov_imm(cpu_pkg::targ_rega, va);
            if (k == 2) begin                                   // Equal pair sets z and eq
                mov_imm(cpu_pkg::targ_regb, va);
            end else begin
                mov_imm(cpu_pkg::targ_regb, cpu_pkg::data_t'($urandom));
            end
            for (int op = 0; op < 16; op++) begin
                if (op == 4 || op == 5)                         // Fresh carry from add
                    emit(enc(cpu_pkg::targ_regd, cpu_pkg::adev_rega, cpu_pkg::bdev_regb,
                             cpu_pkg::op_add, cpu_pkg::cond_always, 1'b1,
                             cpu_pkg::am_direct, 8'd0));
                emit(enc(cpu_pkg::targ_uart, cpu_pkg::adev_rega, cpu_pkg::bdev_regb,
                         cpu_pkg::alu_op_e'(op), cpu_pkg::cond_always, 1'b1,
                         cpu_pkg::am_direct, 8'd0));
            end
            emit(enc(cpu_pkg::targ_regd, cpu_pkg::adev_rega, cpu_pkg::bdev_regb, cpu_pkg::op_sub,
                     cpu_pkg::cond_always, 1'b1, cpu_pkg::am_direct, 8'd0));
            for (int cd = 1; cd <= 8; cd++) begin                // Conditional moves c..ne
                mov_imm(cpu_pkg::targ_regc, 8'd0);
                emit(enc(cpu_pkg::targ_regc, cpu_pkg::adev_zero, cpu_pkg::bdev_immed,
                         cpu_pkg::op_pass_b, cpu_pkg::cond_e'(cd), 1'b0, cpu_pkg::am_direct,
                         cpu_pkg::data_t'(16 * cd + 1)));
                emit(enc(cpu_pkg::targ_uart, cpu_pkg::adev_regc, cpu_pkg::bdev_immed,
                         cpu_pkg::op_pass_a, cpu_pkg::cond_always, 1'b0, cpu_pkg::am_direct, 8'd0));
            end
        end
        jump(cpu_pkg::cond_always, cpu_pkg::data_t'(plen));
    endtask

    task automatic ram_prog();
        plen = 0;
        for (int i = 0; i < 4; i++) begin                        // Direct stores at 0x10..
            mov_imm(cpu_pkg::targ_rega, cpu_pkg::data_t'($urandom));
            emit(enc(cpu_pkg::targ_ram, cpu_pkg::adev_rega, cpu_pkg::bdev_immed, cpu_pkg::op_pass_a,
                     cpu_pkg::cond_always, 1'b0, cpu_pkg::am_direct, cpu_pkg::data_t'(16 + i)));
        end
        mov_imm(cpu_pkg::targ_mar, 8'h80);
        for (int i = 0; i < 4; i++) begin                        // MAR stores with MAR += 1
            mov_imm(cpu_pkg::targ_rega, cpu_pkg::data_t'($urandom));
            emit(enc(cpu_pkg::targ_ram, cpu_pkg::adev_rega, cpu_pkg::bdev_immed, cpu_pkg::op_pass_a,
                     cpu_pkg::cond_always, 1'b0, cpu_pkg::am_register, 8'd0));
            emit(enc(cpu_pkg::targ_mar, cpu_pkg::adev_mar, cpu_pkg::bdev_immed, cpu_pkg::op_add,
                     cpu_pkg::cond_always, 1'b0, cpu_pkg::am_direct, 8'd1));
        end
        for (int j = 3; j >= 0; j--) begin                       // Reverse order with interleaved reads
            emit(enc(cpu_pkg::targ_uart, cpu_pkg::adev_zero, cpu_pkg::bdev_ram, cpu_pkg::op_pass_b,
                     cpu_pkg::cond_always, 1'b0, cpu_pkg::am_direct, cpu_pkg::data_t'(16 + j)));
            mov_imm(cpu_pkg::targ_mar, cpu_pkg::data_t'(128 + j));
            emit(enc(cpu_pkg::targ_uart, cpu_pkg::adev_zero, cpu_pkg::bdev_ram, cpu_pkg::op_pass_b,
                     cpu_pkg::cond_always, 1'b0, cpu_pkg::am_register, 8'd0));
        end
        jump(cpu_pkg::cond_always, cpu_pkg::data_t'(plen));
    endtask

    // Poll di and echo each byte plus one
    task automatic echo_prog();
        plen = 0;
        jump(cpu_pkg::cond_di, 8'd2);
        jump(cpu_pkg::cond_always, 8'd0);
        emit(enc(cpu_pkg::targ_uart, cpu_pkg::adev_uart, cpu_pkg::bdev_immed, cpu_pkg::op_add,
                 cpu_pkg::cond_always, 1'b0, cpu_pkg::am_direct, 8'd1));
        jump(cpu_pkg::cond_always, 8'd0);
    endtask

    // Wait on do before every write
    task automatic paced_output_prog();
        plen = 0;
        mov_imm(cpu_pkg::targ_rega, cpu_pkg::data_t'($urandom));
        jump(cpu_pkg::cond_do, 8'd3);
        jump(cpu_pkg::cond_always, 8'd1);
        emit(enc(cpu_pkg::targ_uart, cpu_pkg::adev_rega, cpu_pkg::bdev_immed, cpu_pkg::op_pass_a,
                 cpu_pkg::cond_always, 1'b0, cpu_pkg::am_direct, 8'd0));
        emit(enc(cpu_pkg::targ_rega, cpu_pkg::adev_rega, cpu_pkg::bdev_immed, cpu_pkg::op_add,
                 cpu_pkg::cond_always, 1'b0, cpu_pkg::am_direct, 8'd37));
        jump(cpu_pkg::cond_always, 8'd1);
    endtask

    // Load with run low, then reset, optional idle and run until done or limit
    task automatic run_test(input string name, input int n_exp, input int limit, input int idle);
        int cyc;
        test_name = name;
        ref_model(n_exp);
        @(negedge clk);
        run = 1'b0;
        for (int i = 0; i < 256; i++) begin
            prog_we = 1'b1;
            prog_addr = cpu_pkg::addr_t'(i);
            prog_data = (i < plen) ? prog[i] : '0;
            @(negedge clk);
        end
        prog_we = 1'b0;
        arst_n = 1'b0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        repeat (idle) @(negedge clk);
        if (idle > 0) check_count({name, " before run"}, 0, got);
        run = 1'b1;
        cyc = 0;
        while (got < n_exp && cyc < limit) begin
            @(posedge clk);
            cyc++;
        end
        @(negedge clk);
        run = 1'b0;
        repeat (3) @(negedge clk);                      // Last strobe lands
        check_count(name, n_exp, got);
    endtask

    always @(posedge clk) begin
        rd_q    <= in_read;
        ready_q <= out_ready;
    end

    // Port source and sink driven on the falling edge
    always @(negedge clk) begin
        if (!arst_n) begin
            in_idx = 0;
            busy = 0;
        end else begin
            in_idx = in_idx + int'(rd_q);               // Advance after a read
        end
        if (drop_out && out_strobe) busy = int'($urandom % 6);
        else if (busy > 0) busy--;
        out_ready = (busy == 0);
        in_valid = (in_idx < in_list.size()) && (!gap_in || ($urandom % 3 == 0));
        in_data = (in_idx < in_list.size()) ? in_list[in_idx] : '0;
    end

    // Compare each strobed byte with the model
    always @(negedge clk) begin
        if (!arst_n) begin
            got = 0;
        end else if (out_strobe) begin
            if (!ready_q) begin
                other_errs++;
                $display("Error: %s wrote a byte while out_ready was low", test_name);
            end
            if (got < exp_q.size()) begin
                check_data(test_name, exp_q[got], out_data);
            end else begin
                other_errs++;
                $display("Error: %s produced more bytes than expected", test_name);
            end
            got++;
        end
    end

    initial begin
        #(2 * LIMIT_SUM * 4);
        $display("Error: simulation ran past its time limit");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        seed_val = $urandom(32'h4ac2_0d2e);
        data_errs = 0;
        count_errs = 0;
        other_errs = 0;
        count_loop_prog();
        run_test("idle_then_count_loop", 5, 200, 20);
        alu_prog();
        run_test("alu_flags", 72, 600, 0);
        ram_prog();
        run_test("ram_addressing", 8, 200, 0);
        for (int i = 0; i < 8; i++) in_list.push_back(cpu_pkg::data_t'($urandom));
        gap_in = 1'b1;
        echo_prog();
        run_test("input_echo", 8, 1500, 0);
        gap_in = 1'b0;
        in_list.delete();
        drop_out = 1'b1;
        paced_output_prog();
        run_test("output_pacing", 12, 1500, 0);
        $display("errors: %0d data, %0d count, %0d other", data_errs, count_errs, other_errs);
        if (data_errs + count_errs + other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
